// File: tb.f
cmd_bridge_pkg.sv
axil_cmd_port.sv
fifo_asy_fast.sv
cmd_fetch.sv
accum_alu.sv
cmd_bridge_top.sv
tb_cmd_bridge.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module cmd_bridge_top
	verilator --lint-only --timing -f tb.f --top-module tb_cmd_bridge

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_cmd_bridge
	./obj_dir/Vtb_cmd_bridge

clean:
	rm -rf obj_dir

// File: tb_cmd_bridge.sv
`timescale 1ns/1ps

module tb_cmd_bridge import cmd_bridge_pkg::*; ();

	localparam int N_TABLE = 22;
	localparam int N_PASSES = 5; // one steady pass and four with random stalls
	localparam int N_FILL = 19; // fifo depth + slice + result reg and one rejected
	localparam int N_MISC = 4; // status and unmapped accesses
	localparam int TIMEOUT_CYCLES = (N_TABLE * N_PASSES + N_FILL + N_MISC) * 40 + 200;

	typedef enum logic [1:0] {RDY_ON, RDY_OFF, RDY_RANDOM} ready_mode_e;

	logic clk_w, clk_r, rst;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic [AXIL_ADDR_BITS-1:0] awaddr, araddr;
	logic [31:0] wdata, rdata, result;
	logic awready, wready, bvalid, arready, rvalid;
	resp_e bresp, rresp;
	logic result_valid, result_ready, drop_pulse;

	// command, expected bresp, expected result or dropped
	logic [31:0] tbl_cmd [N_TABLE];
	resp_e tbl_resp [N_TABLE];
	logic [31:0] tbl_exp [N_TABLE];
	logic tbl_drop [N_TABLE];
	int tbl_len = 0;

	logic [31:0] exp_q [$]; // results the dut still owes in order
	logic [31:0] exp_head;
	int drop_count = 0;
	int drops_expected = 0;
	int cycles = 0;
	ready_mode_e ready_mode = RDY_ON;
	resp_e resp;
	logic [31:0] rd_word;

	cmd_bridge_top #(.DATA_BITS(32), .ADDR_BITS(4)) UUT (
		.clk_w(clk_w), .clk_r(clk_r), .rst(rst),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.result_valid(result_valid), .result(result), .result_ready(result_ready),
		.drop_pulse(drop_pulse)
	);

	initial begin
		clk_r = 1'b0;
		forever #5 clk_r = ~clk_r; // 10 ns
	end

	initial begin
		clk_w = 1'b0;
		forever #7 clk_w = ~clk_w; // 14 ns with no phase relation to clk_r
	end

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_resp(input string name, input resp_e got, input resp_e exp);
		if (got !== exp)
			stop_on_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_result(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_status(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic add_entry(input logic [31:0] cmd, input logic [31:0] exp,
			input logic drop);
		tbl_cmd[tbl_len] = cmd;
		tbl_resp[tbl_len] = RESP_OKAY; // illegal opcodes are still accepted on the bus
		tbl_exp[tbl_len] = exp;
		tbl_drop[tbl_len] = drop;
		tbl_len++;
	endtask

	// starts with LOAD so every pass gives the same results
	task automatic build_table();
		add_entry(32'h1000_1234, 32'h0000_1234, 1'b0); // load
		add_entry(32'h2000_0010, 32'h0000_1244, 1'b0);
		add_entry(32'h3000_0044, 32'h0000_1200, 1'b0);
		add_entry(32'h4000_00ff, 32'h0000_12ff, 1'b0);
		add_entry(32'h3abc_2000, 32'hffff_f2ff, 1'b0); // sub wraps with junk in 27:16
		add_entry(32'h2000_0d01, 32'h0000_0000, 1'b0); // add wraps to zero
		add_entry(32'h3000_0001, 32'hffff_ffff, 1'b0);
		add_entry(32'h2000_ffff, 32'h0000_fffe, 1'b0);
		add_entry(32'h0000_5555, 32'h0, 1'b1); // opcode 0
		add_entry(32'h4000_ffff, 32'h0000_0001, 1'b0); // acc untouched by the drop
		add_entry(32'hf123_4567, 32'h0, 1'b1);
		add_entry(32'h5000_0001, 32'h0, 1'b1); // back to back drops
		add_entry(32'h2000_0002, 32'h0000_0003, 1'b0);
		add_entry(32'h1fff_abcd, 32'h0000_abcd, 1'b0);
		add_entry(32'h4000_5a5a, 32'h0000_f197, 1'b0);
		add_entry(32'h3000_f197, 32'h0000_0000, 1'b0);
		add_entry(32'h3000_8000, 32'hffff_8000, 1'b0);
		add_entry(32'h3000_8000, 32'hffff_0000, 1'b0);
		add_entry(32'h2000_ffff, 32'hffff_ffff, 1'b0);
		add_entry(32'h2000_0001, 32'h0000_0000, 1'b0);
		add_entry(32'h8000_0000, 32'h0, 1'b1);
		add_entry(32'h4000_0000, 32'h0000_0000, 1'b0); // last legal one flushes the drop
	endtask

	task automatic axil_write(input logic [AXIL_ADDR_BITS-1:0] addr, input logic [31:0] data,
			output resp_e got);
		@(negedge clk_w);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(posedge clk_w);
		while (!(awready && wready)) @(posedge clk_w);
		@(negedge clk_w);
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(posedge clk_w);
		while (!bvalid) @(posedge clk_w); // bready tied high
		got = bresp;
	endtask

	task automatic axil_read(input logic [AXIL_ADDR_BITS-1:0] addr, output logic [31:0] data,
			output resp_e got);
		@(negedge clk_w);
		araddr = addr;
		arvalid = 1'b1;
		@(posedge clk_w);
		while (!arready) @(posedge clk_w);
		@(negedge clk_w);
		arvalid = 1'b0;
		@(posedge clk_w);
		while (!rvalid) @(posedge clk_w); // rready tied high
		data = rdata;
		got = rresp;
	endtask

	// result is queued before the write since it can beat bvalid back
	task automatic apply_entry(input int i);
		resp_e got;
		if (tbl_resp[i] == RESP_OKAY && !tbl_drop[i])
			exp_q.push_back(tbl_exp[i]);
		if (tbl_drop[i])
			drops_expected++;
		axil_write(ADDR_CMD, tbl_cmd[i], got);
		check_resp("bresp", got, tbl_resp[i]);
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0) @(posedge clk_r);
		repeat (10) @(posedge clk_r); // room for a stray extra result
		check_result("drop_count", 32'(drop_count), 32'(drops_expected));
	endtask

	// result and drop monitor
	always @(posedge clk_r) begin
		if (!rst) begin
			if (drop_pulse)
				drop_count++;
			if (result_valid && result_ready) begin
				if (exp_q.size() == 0) begin
					stop_on_error("a result appeared when none was outstanding");
				end else begin
					exp_head = exp_q.pop_front();
					check_result("result", result, exp_head);
				end
			end
		end
	end

	// result_ready pattern
	initial begin
		void'($urandom(32'h9e28)); // seed once for the stall pattern
		forever begin
			@(negedge clk_r);
			case (ready_mode)
				RDY_ON: result_ready = 1'b1;
				RDY_OFF: result_ready = 1'b0;
				default: result_ready = ($urandom % 3) != 0; // stall about one in three
			endcase
		end
	end

	initial begin
		forever begin
			@(posedge clk_r);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
				stop_on_error("timeout: the run did not finish in the cycle budget");
		end
	end

	initial begin
		rst = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b1;
		result_ready = 1'b1;
		build_table();
		repeat (3) @(negedge clk_r);
		rst = 1'b0;

		if (bvalid || rvalid || awready || wready || arready || result_valid || drop_pulse)
			stop_on_error("a handshake output was high right after reset");

		// status and address map
		axil_read(ADDR_STATUS, rd_word, resp);
		check_resp("rresp", resp, RESP_OKAY);
		check_status("status", rd_word, 32'h0000_000f); // 15 free and not full
		axil_write(4'h8, 32'h1000_0001, resp);
		check_resp("bresp unmapped", resp, RESP_SLVERR);
		axil_read(4'hc, rd_word, resp);
		check_resp("rresp unmapped", resp, RESP_SLVERR);
		check_status("rdata unmapped", rd_word, 32'h0);

		// opcodes and drops without stalls
		for (int i = 0; i < tbl_len; i++)
			apply_entry(i);
		wait_drained();

		// fill everything with the result port blocked
		ready_mode = RDY_OFF;
		for (int i = 0; i < N_FILL; i++) begin
			if (i < N_FILL - 1)
				exp_q.push_back(32'h0000_1000 + 32'(i));
			axil_write(ADDR_CMD, (i == 0) ? 32'h1000_1000 : 32'h2000_0001, resp);
			check_resp("bresp fill", resp, (i < N_FILL - 1) ? RESP_OKAY : RESP_SLVERR);
		end
		axil_read(ADDR_STATUS, rd_word, resp);
		check_resp("rresp full", resp, RESP_OKAY);
		check_status("status full", rd_word, 32'h0000_0100); // no space and full bit set
		ready_mode = RDY_ON;
		wait_drained();

		// long run with random back-pressure
		ready_mode = RDY_RANDOM;
		for (int pass = 1; pass < N_PASSES; pass++) begin
			for (int i = 0; i < tbl_len; i++)
				apply_entry(i);
		end
		wait_drained();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: cmd_bridge_top.sv
`timescale 1ns/1ps

module cmd_bridge_top import cmd_bridge_pkg::*; #(
	parameter int DATA_BITS = 32,
	parameter int ADDR_BITS = 4 // fifo of 1 << ADDR_BITS words
) (
	input  logic                      clk_w,
	input  logic                      clk_r,
	input  logic                      rst,
	// axi4-lite host port, clk_w
	input  logic                      awvalid,
	input  logic [AXIL_ADDR_BITS-1:0] awaddr,
	output logic                      awready,
	input  logic                      wvalid,
	input  logic [DATA_BITS-1:0]      wdata,
	output logic                      wready,
	output logic                      bvalid,
	output resp_e                     bresp,
	input  logic                      bready,
	input  logic                      arvalid,
	input  logic [AXIL_ADDR_BITS-1:0] araddr,
	output logic                      arready,
	output logic                      rvalid,
	output logic [DATA_BITS-1:0]      rdata,
	output resp_e                     rresp,
	input  logic                      rready,
	// result stream, clk_r
	output logic                      result_valid,
	output logic [DATA_BITS-1:0]      result,
	input  logic                      result_ready,
	output logic                      drop_pulse
);

	// host side of the fifo
	logic                 en_w, full_w, near_full_w;
	logic [DATA_BITS-1:0] data_w;
	logic [ADDR_BITS-1:0] space_count;
	// clk_r side
	logic                    en_r, empty_r;
	logic [DATA_BITS-1:0]    data_r;
	logic                    cmd_valid, cmd_ready;
	opcode_e                 cmd_op;
	logic [OPERAND_BITS-1:0] cmd_operand;

	axil_cmd_port #(.DATA_BITS(DATA_BITS), .ADDR_BITS(ADDR_BITS)) u_port (
		.clk_w(clk_w), .rst(rst),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.full_w(full_w), .near_full_w(near_full_w), .space_count(space_count),
		.en_w(en_w), .data_w(data_w)
	);

	// near_empty_r and data_count have no consumer here
	fifo_asy_fast #(.DATA_BITS(DATA_BITS), .ADDR_BITS(ADDR_BITS)) u_fifo (
		.rst(rst),
		.clk_w(clk_w), .en_w(en_w), .data_w(data_w),
		.full_w(full_w), .near_full_w(near_full_w), .space_count(space_count),
		.clk_r(clk_r), .en_r(en_r), .data_r(data_r),
		.empty_r(empty_r), .near_empty_r(), .data_count()
	);

	cmd_fetch #(.DATA_BITS(DATA_BITS)) u_fetch (
		.clk_r(clk_r), .rst(rst),
		.data_r(data_r), .empty_r(empty_r), .en_r(en_r),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_operand(cmd_operand),
		.cmd_ready(cmd_ready), .drop_pulse(drop_pulse)
	);

	accum_alu #(.DATA_BITS(DATA_BITS)) u_alu (
		.clk_r(clk_r), .rst(rst),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_operand(cmd_operand),
		.cmd_ready(cmd_ready),
		.result_valid(result_valid), .result(result), .result_ready(result_ready)
	);

endmodule

// File: accum_alu.sv
`timescale 1ns/1ps

module accum_alu import cmd_bridge_pkg::*; #(
	parameter int DATA_BITS = 32
) (
	input  logic                    clk_r,
	input  logic                    rst,
	// command slice from cmd_fetch
	input  logic                    cmd_valid,
	input  opcode_e                 cmd_op,
	input  logic [OPERAND_BITS-1:0] cmd_operand,
	output logic                    cmd_ready,
	// result stream
	output logic                    result_valid,
	output logic [DATA_BITS-1:0]    result,
	input  logic                    result_ready
);

	logic [DATA_BITS-1:0] acc; // also the result register
	logic [DATA_BITS-1:0] acc_next;
	logic [DATA_BITS-1:0] operand_ext;
	logic accept; // command taken this cycle

	assign operand_ext = DATA_BITS'(cmd_operand); // zero-extend

	// stall only while a result sits unread
	assign cmd_ready = !(result_valid && !result_ready);
	assign accept    = cmd_valid && cmd_ready;

	always_comb begin
		case (cmd_op)
			OP_LOAD: acc_next = operand_ext;
			OP_ADD:  acc_next = acc + operand_ext; // mod 2^32
			OP_SUB:  acc_next = acc - operand_ext;
			OP_XOR:  acc_next = acc ^ operand_ext;
			default: acc_next = acc; // fetch never passes these
		endcase
	end

	always_ff @(posedge clk_r) begin
		if (rst) begin
			acc          <= '0;
			result_valid <= 1'b0;
		end else begin
			if (accept)
				acc <= acc_next;
			if (accept)
				result_valid <= 1'b1;
			else if (result_ready)
				result_valid <= 1'b0;
		end
	end

	// acc only moves on accept, and accept waits for the old result to go
	assign result = acc;

	a_result_hold: assert property (@(posedge clk_r) disable iff (rst)
		result_valid && !result_ready |=> result_valid && $stable(result))
		else $error("accum_alu: result changed while stalled");

endmodule

// File: cmd_fetch.sv
`timescale 1ns/1ps

module cmd_fetch import cmd_bridge_pkg::*; #(
	parameter int DATA_BITS = 32
) (
	input  logic                    clk_r,
	input  logic                    rst,
	// fifo read side
	input  logic [DATA_BITS-1:0]    data_r,
	input  logic                    empty_r,
	output logic                    en_r,
	// command slice to accum_alu
	output logic                    cmd_valid,
	output opcode_e                 cmd_op,
	output logic [OPERAND_BITS-1:0] cmd_operand,
	input  logic                    cmd_ready,
	output logic                    drop_pulse // one cycle per illegal opcode
);

	opcode_e head_op;
	logic head_legal;

	assign head_op = opcode_e'(data_r[OPC_MSB:OPC_LSB]);

	always_comb begin
		case (head_op)
			OP_LOAD, OP_ADD, OP_SUB, OP_XOR: head_legal = 1'b1;
			default: head_legal = 1'b0; // unknown encoding
		endcase
	end

	// pop when the slice is free or drains this cycle
	assign en_r = !empty_r && (!cmd_valid || cmd_ready);

	always_ff @(posedge clk_r) begin
		if (rst) begin
			cmd_valid  <= 1'b0;
			drop_pulse <= 1'b0;
		end else begin
			drop_pulse <= en_r && !head_legal; // popped but thrown away
			if (en_r && head_legal)
				cmd_valid <= 1'b1;
			else if (cmd_ready)
				cmd_valid <= 1'b0;
		end
	end

	// slice payload
	always_ff @(posedge clk_r) begin
		if (en_r && head_legal) begin
			cmd_op      <= head_op;
			cmd_operand <= data_r[OPERAND_BITS-1:0]; // bits 27:16 ignored
		end
	end

	// held command must not change under the consumer
	a_slice_hold: assert property (@(posedge clk_r) disable iff (rst)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_op) && $stable(cmd_operand))
		else $error("cmd_fetch: slice changed while stalled");

endmodule

// File: fifo_asy_fast.sv
`timescale 1ns/1ps

module fifo_asy_fast #(
	parameter int DATA_BITS = 32,
	parameter int ADDR_BITS = 4
) (
	input  logic                 rst, // synchronous and seen by both clocks
	// write side
	input  logic                 clk_w,
	input  logic                 en_w,
	input  logic [DATA_BITS-1:0] data_w,
	output logic                 full_w,
	output logic                 near_full_w, // one slot left
	output logic [ADDR_BITS-1:0] space_count, // free slots as clk_w sees them
	// read side
	input  logic                 clk_r,
	input  logic                 en_r,
	output logic [DATA_BITS-1:0] data_r, // head word valid while !empty_r
	output logic                 empty_r,
	output logic                 near_empty_r, // only the head word left
	output logic [ADDR_BITS-1:0] data_count   // words queued behind the head
);

	localparam int DEPTH = 1 << ADDR_BITS;

	// ram keeps one slot open to tell full from empty and the head register
	// adds one more word so the total is DEPTH
	logic [DATA_BITS-1:0] mem [DEPTH];

	// write domain
	logic [ADDR_BITS-1:0] ptr_w, ptr_w_inc, gray_w;
	logic [ADDR_BITS-1:0] gray_r_s1, gray_r_s2, ptr_r_sync;
	// read domain
	logic [ADDR_BITS-1:0] ptr_r, ptr_r_inc, gray_r;
	logic [ADDR_BITS-1:0] gray_w_s1, gray_w_s2, ptr_w_sync;
	logic mem_empty; // nothing in ram from clk_r view
	logic head_valid; // data_r holds a word
	logic load_head; // move next ram word into data_r

	function automatic logic [ADDR_BITS-1:0] bin2gray(input logic [ADDR_BITS-1:0] b);
		return b ^ (b >> 1);
	endfunction

	function automatic logic [ADDR_BITS-1:0] gray2bin(input logic [ADDR_BITS-1:0] g);
		logic [ADDR_BITS-1:0] b;
		b[ADDR_BITS-1] = g[ADDR_BITS-1];
		for (int i = ADDR_BITS - 2; i >= 0; i--)
			b[i] = b[i+1] ^ g[i]; // running xor from the top
		return b;
	endfunction

	// write clock side
	assign ptr_w_inc = ptr_w + 1'b1;

	always_ff @(posedge clk_w) begin
		if (rst) begin
			ptr_w  <= '0;
			gray_w <= '0;
		end else if (en_w && !full_w) begin
			ptr_w  <= ptr_w_inc;
			gray_w <= bin2gray(ptr_w_inc); // registered so only one bit moves per push
		end
	end

	always_ff @(posedge clk_w) begin
		if (en_w && !full_w)
			mem[ptr_w] <= data_w;
	end

	// read pointer into clk_w through two flops
	always_ff @(posedge clk_w) begin
		if (rst) begin
			gray_r_s1 <= '0;
			gray_r_s2 <= '0;
		end else begin
			gray_r_s1 <= gray_r;
			gray_r_s2 <= gray_r_s1;
		end
	end

	assign ptr_r_sync = gray2bin(gray_r_s2);

	// stale read pointer means space is under-reported and never over
	assign space_count = ptr_r_sync - ptr_w_inc;
	assign full_w      = (space_count == '0);
	assign near_full_w = (space_count == ADDR_BITS'(1));

	// read clock side
	assign ptr_r_inc = ptr_r + 1'b1;

	// write pointer into clk_r
	always_ff @(posedge clk_r) begin
		if (rst) begin
			gray_w_s1 <= '0;
			gray_w_s2 <= '0;
		end else begin
			gray_w_s1 <= gray_w;
			gray_w_s2 <= gray_w_s1;
		end
	end

	assign ptr_w_sync = gray2bin(gray_w_s2);
	assign mem_empty  = (ptr_w_sync == ptr_r);

	// refill the head when it is free or popped this cycle
	assign load_head = !mem_empty && (!head_valid || en_r);

	always_ff @(posedge clk_r) begin
		if (rst) begin
			ptr_r      <= '0;
			gray_r     <= '0;
			head_valid <= 1'b0;
		end else if (load_head) begin
			ptr_r      <= ptr_r_inc;
			gray_r     <= bin2gray(ptr_r_inc);
			head_valid <= 1'b1;
		end else if (en_r) begin
			head_valid <= 1'b0; // last word popped
		end
	end

	always_ff @(posedge clk_r) begin
		if (load_head)
			data_r <= mem[ptr_r];
	end

	assign empty_r      = !head_valid;
	assign near_empty_r = head_valid && mem_empty;
	assign data_count   = ptr_w_sync - ptr_r; // conservative since the writer may be ahead

	a_no_pop_empty: assert property (@(posedge clk_r) disable iff (rst)
		en_r |-> !empty_r)
		else $error("fifo_asy_fast: pop while empty");

	a_no_push_full: assert property (@(posedge clk_w) disable iff (rst)
		en_w |-> !full_w)
		else $error("fifo_asy_fast: push while full");

endmodule

// File: axil_cmd_port.sv
`timescale 1ns/1ps

module axil_cmd_port import cmd_bridge_pkg::*; #(
	parameter int DATA_BITS = 32,
	parameter int ADDR_BITS = 4
) (
	input  logic                      clk_w,
	input  logic                      rst,
	// write address / data / response
	input  logic                      awvalid,
	input  logic [AXIL_ADDR_BITS-1:0] awaddr,
	output logic                      awready,
	input  logic                      wvalid,
	input  logic [DATA_BITS-1:0]      wdata,
	output logic                      wready,
	output logic                      bvalid,
	output resp_e                     bresp,
	input  logic                      bready,
	// read address / data
	input  logic                      arvalid,
	input  logic [AXIL_ADDR_BITS-1:0] araddr,
	output logic                      arready,
	output logic                      rvalid,
	output logic [DATA_BITS-1:0]      rdata,
	output resp_e                     rresp,
	input  logic                      rready,
	// fifo write side
	input  logic                      full_w,
	input  logic                      near_full_w,
	input  logic [ADDR_BITS-1:0]      space_count,
	output logic                      en_w,
	output logic [DATA_BITS-1:0]      data_w
);

	typedef enum logic [1:0] {
		ST_IDLE,  // waiting for a request
		ST_WRESP, // bvalid up
		ST_RRESP  // rvalid up
	} state_e;

	state_e state;
	logic wr_accept; // aw and w handshake this cycle
	logic rd_accept; // ar handshake this cycle
	logic wr_to_cmd; // write hits the command register
	logic [DATA_BITS-1:0] status_word;

	// both halves of a write must be present, writes win over reads
	assign wr_accept = (state == ST_IDLE) && awvalid && wvalid;
	assign rd_accept = (state == ST_IDLE) && arvalid && !(awvalid && wvalid);

	assign awready = wr_accept; // one cycle together with wready
	assign wready  = wr_accept;
	assign arready = rd_accept;

	assign wr_to_cmd = (awaddr == ADDR_CMD);

	// push on the handshake edge, no strobes so the whole word goes in
	assign en_w   = wr_accept && wr_to_cmd && !full_w;
	assign data_w = wdata;

	assign bvalid = (state == ST_WRESP);
	assign rvalid = (state == ST_RRESP);

	always_comb begin
		status_word = '0;
		status_word[ADDR_BITS-1:0] = space_count; // free slots in the low byte
		status_word[STAT_FULL_BIT] = full_w;
		status_word[STAT_NEAR_FULL_BIT] = near_full_w;
	end

	always_ff @(posedge clk_w) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (wr_accept)
						state <= ST_WRESP;
					else if (rd_accept)
						state <= ST_RRESP;
				end
				ST_WRESP: if (bready) state <= ST_IDLE; // hold until taken
				ST_RRESP: if (rready) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// response payload captured at acceptance
	always_ff @(posedge clk_w) begin
		if (wr_accept)
			bresp <= (wr_to_cmd && !full_w) ? RESP_OKAY : RESP_SLVERR; // full or unmapped
		if (rd_accept) begin
			if (araddr == ADDR_STATUS) begin
				rdata <= status_word;
				rresp <= RESP_OKAY;
			end else begin
				rdata <= '0; // unmapped reads as zero
				rresp <= RESP_SLVERR;
			end
		end
	end

	// every push gets an okay response on the next cycle
	a_push_okay: assert property (@(posedge clk_w) disable iff (rst)
		en_w |=> bvalid && bresp == RESP_OKAY)
		else $error("axil_cmd_port: push not answered with okay");

	// write response held steady until the host takes it
	a_b_hold: assert property (@(posedge clk_w) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("axil_cmd_port: bvalid dropped or bresp changed");

endmodule

// File: cmd_bridge_pkg.sv
package cmd_bridge_pkg;

	// command word layout: [31:28] opcode, [27:16] ignored, [15:0] operand
	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 28;
	localparam int OPERAND_BITS = 16; // zero-extended to the accumulator width

	// opcode field, every other encoding is illegal and gets dropped
	typedef enum logic [3:0] {
		OP_LOAD = 4'h1, // acc = operand
		OP_ADD  = 4'h2, // acc = acc + operand, wraps
		OP_SUB  = 4'h3, // acc = acc - operand, wraps
		OP_XOR  = 4'h4  // acc = acc ^ operand
	} opcode_e;

	// axi response codes, only the two we ever send
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// host register map
	localparam int AXIL_ADDR_BITS = 4;
	localparam logic [AXIL_ADDR_BITS-1:0] ADDR_CMD    = 4'h0; // write only, pushes a command
	localparam logic [AXIL_ADDR_BITS-1:0] ADDR_STATUS = 4'h4; // read only, fifo status

	// status word: space_count in [7:0]
	localparam int STAT_FULL_BIT      = 8;
	localparam int STAT_NEAR_FULL_BIT = 9;

	// builds a command word from its fields
	function automatic logic [31:0] make_cmd(input logic [3:0] opc,
			input logic [OPERAND_BITS-1:0] operand);
		logic [31:0] w;
		w = '0;
		w[OPC_MSB:OPC_LSB] = opc;
		w[OPERAND_BITS-1:0] = operand;
		return w;
	endfunction

endpackage
